//--- rtl/agu_consts.svh
// Width macros for the address generation unit

`ifndef AGU_CONSTS_SVH
`define AGU_CONSTS_SVH

// Data path width
`define AGU_XLEN 32

// Bus address width
`define AGU_ADDR_SIZE 32

// One write-mask bit per data byte
`define AGU_MASK_W (`AGU_XLEN/8)

// AMO state register width
`define AGU_STATE_W 3

`endif

//--- rtl/agu_pkg.sv
// Enums and packed structs for the issue, commit, bus and ALU channels
`include "agu_consts.svh"

package agu_pkg;

  // Instruction class from decode
  typedef enum logic [1:0] {
    LOAD  = 2'd0,
    STORE = 2'd1,
    AMO   = 2'd2,
    NONE  = 2'd3
  } agu_kind_e;

  // Access size, same coding as the bus size field
  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } agu_size_e;

  // AMO operation, also the ALU opcode
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SWAP = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    MAX  = 4'd5,
    MIN  = 4'd6,
    MAXU = 4'd7,
    MINU = 4'd8
  } agu_amo_e;

  typedef struct packed {
    agu_kind_e kind;
    agu_size_e size;
    agu_amo_e  amo;
  } agu_info_t;

  // One issued memory instruction
  typedef struct packed {
    logic [`AGU_XLEN-1:0] rs1;
    logic [`AGU_XLEN-1:0] rs2;
    logic [`AGU_XLEN-1:0] imm;
    agu_info_t            info;
  } agu_req_t;

  // AMO sequence states
  typedef enum logic [`AGU_STATE_W-1:0] {
    IDLE    = 3'd0,
    FIRST   = 3'd1,
    WAIT2ND = 3'd2,
    SECOND  = 3'd3,
    AMOALU  = 3'd4,
    AMORDY  = 3'd5,
    WBCK    = 3'd6
  } agu_state_e;

  typedef struct packed {
    logic [`AGU_ADDR_SIZE-1:0] addr;
    logic                      read;
    logic [`AGU_XLEN-1:0]      wdata;
    logic [`AGU_MASK_W-1:0]    wmask;
    logic                      lock;
    agu_size_e                 size;
  } icb_cmd_t;

  typedef struct packed {
    logic                 err;
    logic [`AGU_XLEN-1:0] rdata;
  } icb_rsp_t;

  // Write-back and commit record
  typedef struct packed {
    logic [`AGU_XLEN-1:0]      wdat;
    logic                      wbck_err;
    logic                      misalgn;
    logic                      ld;
    logic                      stamo;
    logic                      buserr;
    logic [`AGU_ADDR_SIZE-1:0] badaddr;
  } agu_cmt_t;

  typedef struct packed {
    logic [`AGU_XLEN-1:0] op1;
    logic [`AGU_XLEN-1:0] op2;
    agu_amo_e             op;
  } alu_req_t;

endpackage

//--- rtl/agu_alu.sv
// Shared arithmetic unit for address addition and AMO operations
`timescale 1ns/1ps
`include "agu_consts.svh"

module agu_alu import agu_pkg::*; (
  input  alu_req_t             req,
  output logic [`AGU_XLEN-1:0] res
);

  logic [`AGU_XLEN-1:0] sum;
  logic                 slt;
  logic                 ult;

  // One adder serves the address and AMOADD
  assign sum = req.op1 + req.op2;

  // Comparators shared by the four max/min flavours
  assign slt = $signed(req.op1) < $signed(req.op2);
  assign ult = req.op1 < req.op2;

  always_comb begin
    case (req.op)
      ADD:     res = sum;
      SWAP:    res = req.op2;
      AND:     res = req.op1 & req.op2;
      OR:      res = req.op1 | req.op2;
      XOR:     res = req.op1 ^ req.op2;
      // Signed pair
      MAX:     res = slt ? req.op2 : req.op1;
      MIN:     res = slt ? req.op1 : req.op2;
      // Unsigned pair
      MAXU:    res = ult ? req.op2 : req.op1;
      MINU:    res = ult ? req.op1 : req.op2;
      // Unused codes fall back to the address add
      default: res = sum;
    endcase
  end

endmodule

//--- rtl/agu_store_align.sv
// Misalignment check, store data replication and store write mask
`timescale 1ns/1ps
`include "agu_consts.svh"

module agu_store_align import agu_pkg::*; (
  input  agu_size_e                 size,
  input  logic [`AGU_ADDR_SIZE-1:0] addr,
  input  logic [`AGU_XLEN-1:0]      rs2,
  output logic                      misalgn,
  output logic [`AGU_XLEN-1:0]      wdata,
  output logic [`AGU_MASK_W-1:0]    wmask
);

  // Base masks before the byte offset shift
  localparam logic [`AGU_MASK_W-1:0] MASK_B = `AGU_MASK_W'(1);
  localparam logic [`AGU_MASK_W-1:0] MASK_H = `AGU_MASK_W'(3);
  localparam logic [`AGU_MASK_W-1:0] MASK_W = {`AGU_MASK_W{1'b1}};

  // Halfword needs bit 0 clear, word needs bits 1:0 clear
  assign misalgn = ((size == HALF) & addr[0])
                 | ((size == WORD) & (|addr[1:0]));

  always_comb begin
    case (size)
      BYTE: begin
        // Byte lane repeated on every lane
        wdata = {(`AGU_XLEN/8){rs2[7:0]}};
        wmask = MASK_B << addr[1:0];
      end
      HALF: begin
        wdata = {(`AGU_XLEN/16){rs2[15:0]}};
        // Low or high half by address bit 1
        wmask = MASK_H << {addr[1], 1'b0};
      end
      default: begin
        wdata = rs2;
        wmask = MASK_W;
      end
    endcase
  end

endmodule

//--- rtl/agu_amo_fsm.sv
// AMO read-modify-write FSM with leftover buffers and bus error bit
`timescale 1ns/1ps
`include "agu_consts.svh"

module agu_amo_fsm import agu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 cmd_ready,
  input  logic                 rsp_valid,
  input  icb_rsp_t             rsp,
  input  logic                 o_ready,
  input  logic [`AGU_XLEN-1:0] alu_res,
  output logic                 rsp_ready,
  output agu_state_e           state,
  output logic [`AGU_XLEN-1:0] leftover,
  output logic [`AGU_XLEN-1:0] leftover_1,
  output logic                 err
);

  agu_state_e state_nxt;
  logic       rsp_hsked;
  logic       first_rsp;
  logic       second_rsp;

  // Responses are never stalled
  assign rsp_ready = 1'b1;
  assign rsp_hsked = rsp_valid & rsp_ready;

  // Read response and write response of the sequence
  assign first_rsp  = (state == FIRST) & rsp_hsked;
  assign second_rsp = (state == SECOND) & rsp_hsked;

  ////////////////////////////////////////////////////////////////////////////
  // State transitions
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        // Locked read accepted by the bus
        if (start) begin
          state_nxt = FIRST;
        end
      end
      FIRST: begin
        if (rsp_hsked) begin
          state_nxt = AMOALU;
        end
      end
      // ALU is free here, so one cycle each
      AMOALU:  state_nxt = AMORDY;
      AMORDY:  state_nxt = WAIT2ND;
      WAIT2ND: begin
        // Write command goes out when the bus takes it
        if (cmd_ready) begin
          state_nxt = SECOND;
        end
      end
      SECOND: begin
        if (rsp_hsked) begin
          state_nxt = WBCK;
        end
      end
      WBCK: begin
        // Old value retired to commit
        if (o_ready) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Leftover buffers
  ////////////////////////////////////////////////////////////////////////////

  // Old memory value, returned on write-back
  always_ff @(posedge clk) begin
    if (first_rsp) begin
      leftover <= rsp.rdata;
    end
  end

  // New value computed from old value and rs2
  always_ff @(posedge clk) begin
    if (state == AMOALU) begin
      leftover_1 <= alu_res;
    end
  end

  // First error blocks the write, second error merges in
  always_ff @(posedge clk) begin
    if (rst) begin
      err <= 1'b0;
    end else if (first_rsp) begin
      err <= rsp.err;
    end else if (second_rsp) begin
      err <= err | rsp.err;
    end
  end

endmodule

//--- rtl/agu_cmd_route.sv
// Operand selection, bus command, commit record and issue handshakes
`timescale 1ns/1ps
`include "agu_consts.svh"

module agu_cmd_route import agu_pkg::*; (
  input  logic                 i_valid,
  input  agu_req_t             i_req,
  input  agu_state_e           state,
  input  logic [`AGU_XLEN-1:0] leftover,
  input  logic [`AGU_XLEN-1:0] leftover_1,
  input  logic                 err,
  input  logic [`AGU_XLEN-1:0] alu_res,
  input  logic                 misalgn,
  input  logic [`AGU_XLEN-1:0] st_wdata,
  input  logic [`AGU_MASK_W-1:0] st_wmask,
  input  logic                 cmd_ready,
  input  logic                 o_ready,
  output alu_req_t             alu_req,
  output logic                 start,
  output logic                 i_ready,
  output logic                 cmd_valid,
  output icb_cmd_t             cmd,
  output logic                 o_valid,
  output agu_cmt_t             o_cmt
);

  logic is_idle, is_wbck;
  logic is_load, is_store, is_amo;
  logic unalgn, algn_ldst, unalgn_ldst, algn_amo, unalgn_amo;
  logic cmd_hsked;

  assign is_idle  = (state == IDLE);
  assign is_wbck  = (state == WBCK);
  assign is_load  = (i_req.info.kind == LOAD);
  assign is_store = (i_req.info.kind == STORE);
  assign is_amo   = (i_req.info.kind == AMO);

  // Only an aligned AMO ever leaves IDLE, so the check counts in IDLE only
  assign unalgn      = is_idle & misalgn;
  assign algn_ldst   = ~unalgn & (is_load | is_store);
  assign unalgn_ldst = unalgn & (is_load | is_store);
  assign algn_amo    = ~unalgn & is_amo;
  assign unalgn_amo  = unalgn & is_amo;

  ////////////////////////////////////////////////////////////////////////////
  // ALU operands
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_req = '{op1: '0, op2: '0, op: ADD};
    case (state)
      // Address is rs1 plus imm, AMOs use offset zero
      IDLE: alu_req = '{op1: i_req.rs1, op2: is_amo ? '0 : i_req.imm, op: ADD};
      AMOALU: alu_req = '{op1: leftover, op2: i_req.rs2, op: i_req.info.amo};
      // Address for the write half of the AMO
      WAIT2ND, SECOND, WBCK: alu_req = '{op1: i_req.rs1, op2: '0, op: ADD};
      default: alu_req = '{op1: '0, op2: '0, op: ADD};
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////////////

  // Commit must be ready too, so command and commit leave together
  assign cmd_valid = (algn_ldst & i_valid & o_ready)
                   | (algn_amo & ((is_idle & i_valid & o_ready) | (state == WAIT2ND)));
  assign cmd_hsked = cmd_valid & cmd_ready;
  assign start     = is_idle & algn_amo & cmd_hsked;

  // AMO retires on the write-back exit, others in the issue cycle
  assign i_ready = algn_amo ? (is_wbck & o_ready) : (cmd_ready & o_ready);

  // Same-cycle commit always waits for the bus side
  assign o_valid = is_wbck
                 | (i_valid & (algn_ldst | unalgn_ldst | unalgn_amo) & cmd_ready);

  ////////////////////////////////////////////////////////////////////////////
  // Command and commit payloads
  ////////////////////////////////////////////////////////////////////////////

  assign cmd.addr  = alu_res[`AGU_ADDR_SIZE-1:0];
  assign cmd.read  = (algn_ldst & is_load) | (algn_amo & is_idle);
  assign cmd.wdata = is_amo ? leftover_1 : st_wdata;
  // Failed read suppresses the AMO write
  assign cmd.wmask = is_amo ? (err ? '0 : {`AGU_MASK_W{1'b1}}) : st_wmask;
  assign cmd.lock  = algn_amo & is_idle;
  assign cmd.size  = i_req.info.size;

  assign o_cmt.wdat     = algn_amo ? leftover : '0;
  assign o_cmt.buserr   = algn_amo & err;
  assign o_cmt.misalgn  = unalgn_ldst | unalgn_amo;
  assign o_cmt.ld       = is_load;
  assign o_cmt.stamo    = is_store | is_amo;
  assign o_cmt.badaddr  = cmd.addr;
  assign o_cmt.wbck_err = o_cmt.buserr | o_cmt.misalgn;

endmodule

//--- rtl/agu_top.sv
// Address generation unit top level, route, ALU, store align and AMO FSM
`timescale 1ns/1ps
`include "agu_consts.svh"

module agu_top import agu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  // Issue
  input  logic     i_valid,
  output logic     i_ready,
  input  agu_req_t i_req,
  // Commit
  output logic     o_valid,
  input  logic     o_ready,
  output agu_cmt_t o_cmt,
  // Bus command
  output logic     cmd_valid,
  input  logic     cmd_ready,
  output icb_cmd_t cmd,
  // Bus response
  input  logic     rsp_valid,
  input  icb_rsp_t rsp
);

  alu_req_t               alu_req;
  logic [`AGU_XLEN-1:0]   alu_res;
  logic                   start;
  agu_state_e             state;
  logic [`AGU_XLEN-1:0]   leftover;
  logic [`AGU_XLEN-1:0]   leftover_1;
  logic                   err;
  logic                   misalgn;
  logic [`AGU_XLEN-1:0]   st_wdata;
  logic [`AGU_MASK_W-1:0] st_wmask;

  agu_cmd_route u_cmd_route (
    .i_valid    (i_valid),
    .i_req      (i_req),
    .state      (state),
    .leftover   (leftover),
    .leftover_1 (leftover_1),
    .err        (err),
    .alu_res    (alu_res),
    .misalgn    (misalgn),
    .st_wdata   (st_wdata),
    .st_wmask   (st_wmask),
    .cmd_ready  (cmd_ready),
    .o_ready    (o_ready),
    .alu_req    (alu_req),
    .start      (start),
    .i_ready    (i_ready),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .o_valid    (o_valid),
    .o_cmt      (o_cmt)
  );

  // Address adder doubles as the AMO datapath
  agu_alu u_alu (
    .req (alu_req),
    .res (alu_res)
  );

  // Checks the computed address
  agu_store_align u_store_align (
    .size    (i_req.info.size),
    .addr    (alu_res[`AGU_ADDR_SIZE-1:0]),
    .rs2     (i_req.rs2),
    .misalgn (misalgn),
    .wdata   (st_wdata),
    .wmask   (st_wmask)
  );

  // Response ready stays internal, it is tied high
  agu_amo_fsm u_amo_fsm (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .cmd_ready  (cmd_ready),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .o_ready    (o_ready),
    .alu_res    (alu_res),
    .rsp_ready  (),
    .state      (state),
    .leftover   (leftover),
    .leftover_1 (leftover_1),
    .err        (err)
  );

endmodule

//--- test/agu_clk_gen.sv
// Testbench clock and reset generator
`timescale 1ns/1ps

module agu_clk_gen #(
  parameter int HALF_PERIOD = 5,
  parameter int RST_CYCLES  = 8
) (
  output logic clk,
  output logic rst
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset held for a fixed number of rising edges
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- test/agu_checker.sv
// Bound assertions on the bus command, commit record and AMO FSM
`timescale 1ns/1ps

module agu_checker import agu_pkg::*; (
  input logic       clk,
  input logic       rst,
  input agu_state_e state,
  input logic       cmd_valid,
  input logic       cmd_ready,
  input icb_cmd_t   cmd,
  input logic       o_valid,
  input logic       o_ready,
  input agu_cmt_t   o_cmt
);

  // Command payload holds while the bus stalls
  a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
    (cmd_valid && !cmd_ready) |=> (!cmd_valid || $stable(cmd)))
    else $error("bus command changed while stalled");

  // Commit payload holds while commit stalls
  a_cmt_stable: assert property (@(posedge clk) disable iff (rst)
    (o_valid && !o_ready) |=> (!o_valid || $stable(o_cmt)))
    else $error("commit record changed while stalled");

  // IDLE is left only through the locked read handshake
  a_idle_exit: assert property (@(posedge clk) disable iff (rst)
    (state == IDLE && !(cmd_valid && cmd_ready && cmd.read && cmd.lock))
      |=> (state == IDLE))
    else $error("FSM left IDLE without a locked read handshake");

  // No commit while the read is in flight
  a_first_quiet: assert property (@(posedge clk) disable iff (rst)
    (state == FIRST) |-> !o_valid)
    else $error("commit raised in FIRST");

endmodule

bind agu_top agu_checker u_agu_checker (
  .clk       (clk),
  .rst       (rst),
  .state     (state),
  .cmd_valid (cmd_valid),
  .cmd_ready (cmd_ready),
  .cmd       (cmd),
  .o_valid   (o_valid),
  .o_ready   (o_ready),
  .o_cmt     (o_cmt)
);

//--- test/agu_tb.sv
// AGU testbench with stimulus, bus memory model, reference model, compare and watchdog
`timescale 1ns/1ps
`include "agu_consts.svh"

module agu_tb import agu_pkg::*; ();

  // 12 aligned loads, 12 aligned stores, 5 misaligned, 9 AMO ops, 1 AMO error
  localparam int NUM_TESTS       = 39;
  localparam int CYCLES_PER_TEST = 40;

  logic     clk;
  logic     rst;
  logic     i_valid = 1'b0;
  logic     i_ready;
  agu_req_t i_req = '0;
  logic     o_valid;
  logic     o_ready;
  agu_cmt_t o_cmt;
  logic     cmd_valid;
  logic     cmd_ready;
  icb_cmd_t cmd;
  logic     rsp_valid;
  icb_rsp_t rsp;

  integer seed    = 32'h546bdeb1;
  integer bp_seed = 32'h546bdeb1 ^ 32'h0000ffff;

  logic [`AGU_XLEN-1:0] mem [16];
  logic                 inject_err = 1'b0;

  // Expectations for the running test
  string    cur_name = "";
  int       test_id = 0;
  icb_cmd_t exp_cmd [2];
  int       exp_ncmd = 0;
  agu_cmt_t exp_cmt;

  // Compare process bookkeeping
  int seen_id = 0;
  int cmd_cnt = 0;
  int cmt_cnt = 0;
  int cmp_errors = 0;
  int test_errors = 0;

  agu_clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  agu_top u_agu_top (
    .clk       (clk),
    .rst       (rst),
    .i_valid   (i_valid),
    .i_ready   (i_ready),
    .i_req     (i_req),
    .o_valid   (o_valid),
    .o_ready   (o_ready),
    .o_cmt     (o_cmt),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  //////////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////////

  function automatic logic [`AGU_XLEN-1:0] merge_bytes(input logic [`AGU_XLEN-1:0] old,
      input logic [`AGU_XLEN-1:0] data, input logic [`AGU_MASK_W-1:0] mask);
    logic [`AGU_XLEN-1:0] r;
    r = old;
    for (int b = 0; b < `AGU_MASK_W; b++) begin
      if (mask[b]) begin
        r[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return r;
  endfunction

  function automatic logic [`AGU_XLEN-1:0] amo_result(input agu_amo_e op,
      input logic [`AGU_XLEN-1:0] a, input logic [`AGU_XLEN-1:0] b);
    case (op)
      SWAP:    return b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      MAX:     return ($signed(a) > $signed(b)) ? a : b;
      MIN:     return ($signed(a) < $signed(b)) ? a : b;
      MAXU:    return (a > b) ? a : b;
      MINU:    return (a < b) ? a : b;
      default: return a + b;
    endcase
  endfunction

  // Expected commands, commit and memory word after one request
  function automatic void ref_model(input agu_req_t req, input logic [`AGU_XLEN-1:0] old,
      input logic err1, output icb_cmd_t c1, output icb_cmd_t c2, output int ncmd,
      output agu_cmt_t cmt, output logic [`AGU_XLEN-1:0] new_val);
    logic [`AGU_ADDR_SIZE-1:0] addr;
    logic [`AGU_XLEN-1:0]      wd;
    logic [`AGU_MASK_W-1:0]    wm;
    logic                      mis;
    logic                      is_amo;
    is_amo = (req.info.kind == AMO);
    // AMOs address with rs1 alone
    addr = is_amo ? req.rs1 : req.rs1 + req.imm;
    case (req.info.size)
      BYTE: begin
        mis = 1'b0;
        wd  = {4{req.rs2[7:0]}};
        wm  = 4'b0001 << addr[1:0];
      end
      HALF: begin
        mis = addr[0];
        wd  = {2{req.rs2[15:0]}};
        wm  = addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        mis = addr[1] | addr[0];
        wd  = req.rs2;
        wm  = 4'b1111;
      end
    endcase
    c1 = '{addr: addr, read: (req.info.kind != STORE), wdata: wd, wmask: wm,
           lock: is_amo, size: req.info.size};
    // AMO write half with the mask blocked after a read error
    c2 = '{addr: addr, read: 1'b0, wdata: amo_result(req.info.amo, old, req.rs2),
           wmask: err1 ? 4'b0000 : 4'b1111, lock: 1'b0, size: req.info.size};
    ncmd = mis ? 0 : (is_amo ? 2 : 1);
    cmt.wdat     = (is_amo && !mis) ? old : '0;
    cmt.misalgn  = mis;
    cmt.ld       = (req.info.kind == LOAD);
    cmt.stamo    = (req.info.kind == STORE) || is_amo;
    cmt.buserr   = is_amo && !mis && err1;
    cmt.badaddr  = addr;
    cmt.wbck_err = cmt.misalgn | cmt.buserr;
    new_val = old;
    if (!mis && req.info.kind == STORE) begin
      new_val = merge_bytes(old, wd, wm);
    end else if (!mis && is_amo && !err1) begin
      new_val = c2.wdata;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////////

  task automatic check_cmd(input string name, input icb_cmd_t exp, input icb_cmd_t act);
    icb_cmd_t e;
    icb_cmd_t a;
    e = exp;
    a = act;
    // Reads carry no write data
    if (exp.read) begin
      e.wdata = '0;
      e.wmask = '0;
      a.wdata = '0;
      a.wmask = '0;
    end
    if (e !== a) begin
      cmp_errors++;
      $display("Error: %s command expected %h actual %h", name, e, a);
    end
  endtask

  task automatic check_cmt(input string name, input agu_cmt_t exp, input agu_cmt_t act);
    if (exp !== act) begin
      cmp_errors++;
      $display("Error: %s commit expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input logic [`AGU_XLEN-1:0] exp,
      input logic [`AGU_XLEN-1:0] act);
    if (exp !== act) begin
      test_errors++;
      $display("Error: %s memory expected %h actual %h", name, exp, act);
    end
  endtask

  // Checks every handshake against the expectations of the running test
  always @(posedge clk) begin
    if (test_id != seen_id) begin
      seen_id = test_id;
      cmd_cnt = 0;
      cmt_cnt = 0;
    end
    if (!rst) begin
      if (cmd_valid && cmd_ready) begin
        if (cmd_cnt < exp_ncmd) begin
          check_cmd(cur_name, exp_cmd[cmd_cnt], cmd);
        end else begin
          cmp_errors++;
          $display("Unexpected bus command in test %s", cur_name);
        end
        cmd_cnt++;
      end
      if (o_valid && o_ready) begin
        if (cmt_cnt == 0) begin
          check_cmt(cur_name, exp_cmt, o_cmt);
        end else begin
          cmp_errors++;
          $display("Extra commit in test %s", cur_name);
        end
        cmt_cnt++;
      end
      // Aligned load or store: command and commit move together
      if (i_valid && exp_ncmd == 1) begin
        if ((cmd_valid && cmd_ready) != (o_valid && o_ready)) begin
          cmp_errors++;
          $display("Command and commit split across cycles in test %s", cur_name);
        end
        if (!(cmd_ready && o_ready) && ((cmd_valid && cmd_ready) || (o_valid && o_ready))) begin
          cmp_errors++;
          $display("Handshake under back-pressure in test %s", cur_name);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Bus memory model
  //////////////////////////////////////////////////////////////////////////

  initial begin : mem_model
    logic                 rsp_due;
    icb_rsp_t             rsp_q;
    logic [`AGU_XLEN-1:0] rnd;
    rsp_due   = 1'b0;
    rsp_q     = '0;
    rsp_valid = 1'b0;
    rsp       = '0;
    cmd_ready = 1'b0;
    o_ready   = 1'b0;
    // Pattern spread over every address bit
    for (int i = 0; i < 16; i++) begin
      mem[i] = 32'h9e3779b9 * (i + 1);
    end
    forever begin
      @(posedge clk);
      if (!rst && cmd_valid && cmd_ready) begin
        rsp_due     = 1'b1;
        rsp_q.rdata = mem[cmd.addr[5:2]];
        // Error only on the AMO locked read
        rsp_q.err   = inject_err & cmd.lock;
        if (!cmd.read) begin
          mem[cmd.addr[5:2]] = merge_bytes(mem[cmd.addr[5:2]], cmd.wdata, cmd.wmask);
        end
      end
      @(negedge clk);
      rsp_valid <= rsp_due;
      rsp       <= rsp_q;
      rsp_due    = 1'b0;
      // Random stalls on both ready inputs
      rnd        = $random(bp_seed);
      cmd_ready <= (rnd[1:0] != 2'b00);
      o_ready   <= (rnd[3:2] != 2'b00);
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////////

  task automatic make_req(input agu_kind_e kind, input agu_size_e size, input agu_amo_e op,
      input logic misal, output agu_req_t r);
    logic [`AGU_XLEN-1:0] rnd;
    logic [`AGU_XLEN-1:0] a;
    logic [1:0]           off;
    r.rs1 = $random(seed);
    r.rs2 = $random(seed);
    rnd   = $random(seed);
    r.imm = rnd & 32'h00000fff;
    r.info.kind = kind;
    r.info.size = size;
    r.info.amo  = op;
    rnd = $random(seed);
    // Byte offset within the word
    case (size)
      BYTE:    off = rnd[1:0];
      HALF:    off = {rnd[1], misal};
      default: off = !misal ? 2'd0 : ((rnd[1:0] == 2'd0) ? 2'd1 : rnd[1:0]);
    endcase
    a = (kind == AMO) ? r.rs1 : r.rs1 + r.imm;
    r.rs1 = r.rs1 - {30'd0, a[1:0]} + {30'd0, off};
  endtask

  task automatic run_test(input string name, input agu_req_t req, input logic err1);
    logic [`AGU_ADDR_SIZE-1:0] addr;
    logic [`AGU_XLEN-1:0]      new_val;
    addr = (req.info.kind == AMO) ? req.rs1 : req.rs1 + req.imm;
    @(negedge clk);
    ref_model(req, mem[addr[5:2]], err1, exp_cmd[0], exp_cmd[1], exp_ncmd, exp_cmt, new_val);
    cur_name   = name;
    inject_err = err1;
    test_id++;
    i_req   <= req;
    i_valid <= 1'b1;
    // Issue completes on the input handshake
    do @(posedge clk); while (!(i_valid && i_ready));
    @(negedge clk);
    i_valid <= 1'b0;
    if (cmd_cnt != exp_ncmd) begin
      test_errors++;
      $display("Test %s sent %0d bus commands instead of %0d", name, cmd_cnt, exp_ncmd);
    end
    if (cmt_cnt != 1) begin
      test_errors++;
      $display("Test %s saw %0d commits instead of one", name, cmt_cnt);
    end
    check_word(name, new_val, mem[addr[5:2]]);
  endtask

  task automatic ldst_tests(input agu_kind_e kind, input agu_size_e size);
    agu_req_t r;
    repeat (4) begin
      make_req(kind, size, ADD, 1'b0, r);
      run_test($sformatf("aligned %s %s", kind.name(), size.name()), r, 1'b0);
    end
  endtask

  task automatic misalign_test(input agu_kind_e kind, input agu_size_e size);
    agu_req_t r;
    make_req(kind, size, ADD, 1'b1, r);
    run_test($sformatf("misaligned %s %s", kind.name(), size.name()), r, 1'b0);
  endtask

  initial begin : main
    agu_req_t r;
    agu_amo_e op;
    @(negedge clk);
    while (rst) @(negedge clk);
    ldst_tests(LOAD, BYTE);
    ldst_tests(LOAD, HALF);
    ldst_tests(LOAD, WORD);
    ldst_tests(STORE, BYTE);
    ldst_tests(STORE, HALF);
    ldst_tests(STORE, WORD);
    misalign_test(LOAD, HALF);
    misalign_test(LOAD, WORD);
    misalign_test(STORE, HALF);
    misalign_test(STORE, WORD);
    misalign_test(AMO, WORD);
    // Every AMO operation in turn
    op = op.first();
    repeat (op.num()) begin
      make_req(AMO, WORD, op, 1'b0, r);
      run_test($sformatf("amo %s", op.name()), r, 1'b0);
      op = op.next();
    end
    // Read error blocks the write
    make_req(AMO, WORD, ADD, 1'b0, r);
    run_test("amo read error", r, 1'b1);
    repeat (2) @(negedge clk);
    $display("Done: %0d compare errors, %0d test errors", cmp_errors, test_errors);
    if (cmp_errors == 0 && test_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Run limit scales with the number of tests
  initial begin : watchdog
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("Timeout: the tests did not complete in %0d cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- src.f
+incdir+rtl
rtl/agu_pkg.sv
rtl/agu_alu.sv
rtl/agu_store_align.sv
rtl/agu_amo_fsm.sv
rtl/agu_cmd_route.sv
rtl/agu_top.sv
test/agu_clk_gen.sv
test/agu_checker.sv
test/agu_tb.sv

//--- Makefile
# Verilator build and run for the address generation unit testbench

VERILATOR ?= verilator
TOP       ?= agu_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard rtl/*.sv rtl/*.svh test/*.sv)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "=== PASS ===" $(LOG) || { echo "=== FAIL ==="; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
